// ==== sources.f ====
source/adc_capture_pkg.sv
source/sample_pacer.sv
source/adc_frame_receiver.sv
source/sample_fifo.sv
source/adc_capture_top.sv
tests/adc_slave_model.sv
tests/adc_capture_checker.sv
tests/adc_capture_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the capture testbench, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
	--top-module adc_capture_tb -o adc_capture_sim &&
./obj_dir/adc_capture_sim ||
{ echo "simulation failed"; exit 1; }

// ==== tests/adc_capture_tb.sv ====
// capture testbench
// clock, reset, phase table, expected-word queue, host pop loop and watchdog
module adc_capture_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic Baud_Rate;
	logic rst_i;
	logic capture_en_i;
	logic spi_ss_o;
	logic spi_sck_o;
	logic spi_miso_i;
	logic rd_pop_i;
	adc_capture_pkg::word_t rd_data_o;
	logic rd_empty_o;
	logic [adc_capture_pkg::FIFO_CNT_BITS-1:0] rd_count_o;

	// slave side
	adc_capture_pkg::sample_t next_sample;
	int frame_cnt;
	// host pops paused
	logic hold_pops;
	// words still owed, oldest first
	adc_capture_pkg::word_t exp_q [$];

	// --------------------------------------------------
	// stimulus table
	// --------------------------------------------------
	adc_capture_pkg::sample_t sample_tab [14] = '{
		16'h8001, 16'h7ffe, 16'h1234, 16'hedcb, 16'h0f0f, 16'hf0f0, 16'h5a5a,
		16'ha5a5, 16'h0001, 16'hfffe, 16'h3c3c, 16'hc3c3, 16'h6996, 16'h9669};
	// per phase: capture enable, frames to wait for, pops held off
	bit phase_en [8] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
	int phase_frames [8] = '{0, 5, 0, 4, 14, 0, 4, 0};
	bit phase_hold [8] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

	// table wraps for long phases
	assign next_sample = sample_tab[frame_cnt % 14];

	adc_capture_top DUT
	(
		.Baud_Rate    (Baud_Rate),
		.rst_i        (rst_i),
		.capture_en_i (capture_en_i),
		.spi_ss_o     (spi_ss_o),
		.spi_sck_o    (spi_sck_o),
		.spi_miso_i   (spi_miso_i),
		.rd_pop_i     (rd_pop_i),
		.rd_data_o    (rd_data_o),
		.rd_empty_o   (rd_empty_o),
		.rd_count_o   (rd_count_o)
	);

	adc_slave_model u_adc
	(
		.spi_ss_i      (spi_ss_o),
		.spi_sck_i     (spi_sck_o),
		.spi_miso_o    (spi_miso_i),
		.next_sample_i (next_sample),
		.frame_cnt_o   (frame_cnt)
	);

	initial
	begin
		Baud_Rate = 1'b0;
		forever #5 Baud_Rate = ~Baud_Rate;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic stop_on_failure();
		$display("TEST FAILED");
		$fatal;
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		stop_on_failure();
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Fail %s expected %h got %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// newer sample on top, a lone trailing sample is dropped
	task automatic queue_pairs(input int first, input int n);
		for (int k = 0; k + 1 < n; k += 2)
			exp_q.push_back({sample_tab[(first + k + 1) % 14], sample_tab[(first + k) % 14]});
	endtask

	// frame counts as finished once its done cycle has passed
	task automatic wait_frames(input int n);
		repeat (n)
		begin
			@(posedge spi_ss_o);
			@(negedge Baud_Rate);
			@(negedge Baud_Rate);
		end
	endtask

	function automatic int watchdog_cycles();
		int total;
		total = 16;
		foreach (phase_frames[i])
			total += (phase_frames[i] + 3) * adc_capture_pkg::SAMPLE_PERIOD;
		return total * 4;
	endfunction

	initial
	begin
		repeat (watchdog_cycles()) @(posedge Baud_Rate);
		fail_run("watchdog expired before all phases finished");
	end

	// host pops and checks every head word
	initial
	begin
		rd_pop_i = 1'b0;
		forever
		begin
			@(negedge Baud_Rate);
			if (!rst_i && !rd_empty_o && !hold_pops)
			begin
				if (exp_q.size() == 0)
					fail_run("word read while none was expected");
				else
				begin
					compare_value("rd_data_o", exp_q.pop_front(), rd_data_o);
					rd_pop_i = 1'b1;
				end
			end
			else
				rd_pop_i = 1'b0;
		end
	end

	// --------------------------------------------------
	// phase loop
	// --------------------------------------------------
	initial
	begin
		int frames_seen;
		frames_seen = 0;
		rst_i = 1'b1;
		capture_en_i = 1'b0;
		hold_pops = 1'b0;
		repeat (16) @(negedge Baud_Rate);
		rst_i = 1'b0;
		compare_value("rd_empty_o", 32'd1, 32'(rd_empty_o));
		compare_value("rd_count_o", 32'd0, 32'(rd_count_o));
		compare_value("spi_ss_o", 32'd1, 32'(spi_ss_o));
		compare_value("spi_sck_o", 32'd1, 32'(spi_sck_o));
		foreach (phase_en[p])
		begin
			// pop gating moves away from the pop process edge
			@(posedge Baud_Rate);
			hold_pops = phase_hold[p];
			@(negedge Baud_Rate);
			capture_en_i = phase_en[p];
			if (phase_en[p])
				queue_pairs(frames_seen, phase_frames[p]);
			wait_frames(phase_frames[p]);
			frames_seen += phase_frames[p];
			// idle or stalled, no frame may start
			if (phase_frames[p] == 0 || phase_hold[p])
				repeat (2 * adc_capture_pkg::SAMPLE_PERIOD) @(negedge Baud_Rate);
			if (phase_hold[p])
				compare_value("rd_count_o", 32'(adc_capture_pkg::AFULL_LEVEL), 32'(rd_count_o));
			compare_value("frame count", frames_seen, frame_cnt);
			compare_value("spi_ss_o", 32'd1, 32'(spi_ss_o));
		end
		compare_value("rd_empty_o", 32'd1, 32'(rd_empty_o));
		compare_value("rd_count_o", 32'd0, 32'(rd_count_o));
		compare_value("words left", 32'd0, exp_q.size());
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== tests/adc_capture_checker.sv ====
// bound assertions on frame shape, idle sck level and buffer count
module adc_capture_checker
(
	input logic                                     Baud_Rate,
	input logic                                     rst_i,
	input logic                                     spi_ss_i,
	input logic                                     spi_sck_i,
	input logic                                     frame_done_i,
	input logic [adc_capture_pkg::FIFO_CNT_BITS-1:0] rd_count_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// --------------------------------------------------
	// frame shape
	// --------------------------------------------------
	// select low for exactly 16 cycles
	// done marks the last of them
	assert property (@(posedge Baud_Rate) disable iff (rst_i)
		$fell(spi_ss_i) |-> ##15 frame_done_i ##1 $rose(spi_ss_i))
		else $error("select low time is not one frame");

	// sck parked high while deselected
	assert property (@(posedge Baud_Rate) disable iff (rst_i)
		spi_ss_i |-> spi_sck_i)
		else $error("sck low while deselected");

	// buffer never over its depth
	assert property (@(posedge Baud_Rate) disable iff (rst_i)
		int'(rd_count_i) <= adc_capture_pkg::FIFO_DEPTH)
		else $error("buffer count above depth");

endmodule

bind adc_capture_top adc_capture_checker u_checker
(
	.Baud_Rate    (Baud_Rate),
	.rst_i        (rst_i),
	.spi_ss_i     (spi_ss_o),
	.spi_sck_i    (spi_sck_o),
	.frame_done_i (frame_done),
	.rd_count_i   (rd_count_o)
);

// ==== tests/adc_slave_model.sv ====
// behavioral serial ADC
// shifts the offered sample out MSB first while selected
module adc_slave_model
(
	input  logic                     spi_ss_i,
	input  logic                     spi_sck_i,
	output logic                     spi_miso_o,
	input  adc_capture_pkg::sample_t next_sample_i,
	output int                       frame_cnt_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// sample being shifted out
	adc_capture_pkg::sample_t cur_sample;

	initial
	begin
		spi_miso_o = 1'b0;
		frame_cnt_o = 0;
		cur_sample = '0;
		forever
		begin
			// new conversion on every select fall
			@(negedge spi_ss_i);
			cur_sample = next_sample_i;
			frame_cnt_o = frame_cnt_o + 1;
			// MSB is ready before the first falling edge
			for (int i = adc_capture_pkg::FRAME_BITS - 1; i >= 0; i--)
			begin
				spi_miso_o = cur_sample[i];
				// next bit after the following rising edge
				if (i > 0)
					@(posedge spi_sck_i);
			end
		end
	end

endmodule

// ==== source/adc_capture_top.sv ====
// capture top level
// pacer, frame receiver and word buffer joined by loose ports
module adc_capture_top
(
	input  logic                                     Baud_Rate,
	input  logic                                     rst_i,
	input  logic                                     capture_en_i,
	output logic                                     spi_ss_o,
	output logic                                     spi_sck_o,
	input  logic                                     spi_miso_i,
	input  logic                                     rd_pop_i,
	output adc_capture_pkg::word_t                   rd_data_o,
	output logic                                     rd_empty_o,
	output logic [adc_capture_pkg::FIFO_CNT_BITS-1:0] rd_count_o
);

	// pacer to receiver
	logic conv_start;
	// last shift cycle, watched by the checker
	logic frame_done;
	// receiver to buffer
	logic word_push;
	adc_capture_pkg::word_t word_data;
	// buffer back to pacer
	logic fifo_afull;

	// --------------------------------------------------
	// conversion pacing
	// --------------------------------------------------
	sample_pacer u_pacer
	(
		.Baud_Rate    (Baud_Rate),
		.rst_i        (rst_i),
		.enable_i     (capture_en_i),
		.fifo_afull_i (fifo_afull),
		.conv_start_o (conv_start)
	);

	// --------------------------------------------------
	// serial frame receive and pairing
	// --------------------------------------------------
	// capture enable doubles as pairing enable
	adc_frame_receiver u_receiver
	(
		.Baud_Rate    (Baud_Rate),
		.rst_i        (rst_i),
		.conv_start_i (conv_start),
		.pair_en_i    (capture_en_i),
		.spi_ss_o     (spi_ss_o),
		.spi_sck_o    (spi_sck_o),
		.spi_miso_i   (spi_miso_i),
		.frame_done_o (frame_done),
		.word_push_o  (word_push),
		.word_data_o  (word_data)
	);

	// --------------------------------------------------
	// host word buffer
	// --------------------------------------------------
	sample_fifo u_fifo
	(
		.Baud_Rate   (Baud_Rate),
		.rst_i       (rst_i),
		.push_i      (word_push),
		.push_data_i (word_data),
		.pop_i       (rd_pop_i),
		.pop_data_o  (rd_data_o),
		.empty_o     (rd_empty_o),
		.afull_o     (fifo_afull),
		.count_o     (rd_count_o)
	);

endmodule

// ==== source/sample_fifo.sv ====
// word buffer, first-word-fall-through
// circular storage with entry count and almost-full flag
module sample_fifo
(
	input  logic                                     Baud_Rate,
	input  logic                                     rst_i,
	input  logic                                     push_i,
	input  adc_capture_pkg::word_t                   push_data_i,
	input  logic                                     pop_i,
	output adc_capture_pkg::word_t                   pop_data_o,
	output logic                                     empty_o,
	output logic                                     afull_o,
	output logic [adc_capture_pkg::FIFO_CNT_BITS-1:0] count_o
);

	// storage
	adc_capture_pkg::word_t mem_q [adc_capture_pkg::FIFO_DEPTH];
	// pointers wrap on their own width
	logic [adc_capture_pkg::FIFO_PTR_BITS-1:0] wr_ptr_q;
	logic [adc_capture_pkg::FIFO_PTR_BITS-1:0] rd_ptr_q;
	// entries held
	logic [adc_capture_pkg::FIFO_CNT_BITS-1:0] count_q;
	// qualified strobes
	logic do_push;
	logic do_pop;

	// pacer keeps pushes below full
	assign do_push = push_i;
	// pop on empty is ignored
	assign do_pop = pop_i && !empty_o;

	// --------------------------------------------------
	// storage write
	// --------------------------------------------------
	always_ff @(posedge Baud_Rate)
	begin
		if (do_push)
		begin
			mem_q[wr_ptr_q] <= push_data_i;
		end
	end

	// --------------------------------------------------
	// pointers and count
	// --------------------------------------------------
	always_ff @(posedge Baud_Rate or posedge rst_i)
	begin
		if (rst_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// push and pop together leave the count alone
			case ({do_push, do_pop})
				2'b10:
				begin
					count_q <= count_q + 1'b1;
				end
				2'b01:
				begin
					count_q <= count_q - 1'b1;
				end
				default:
				begin
					count_q <= count_q;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// head word shows without a pop
	assign pop_data_o = mem_q[rd_ptr_q];
	assign empty_o = (count_q == '0);
	assign afull_o = (count_q >= adc_capture_pkg::AFULL_LEVEL);
	assign count_o = count_q;

endmodule

// ==== source/adc_frame_receiver.sv ====
// serial frame receiver
// select and clock generation, falling-edge shift in, two-frame pairing
module adc_frame_receiver
(
	input  logic                   Baud_Rate,
	input  logic                   rst_i,
	input  logic                   conv_start_i,
	input  logic                   pair_en_i,
	output logic                   spi_ss_o,
	output logic                   spi_sck_o,
	input  logic                   spi_miso_i,
	output logic                   frame_done_o,
	output logic                   word_push_o,
	output adc_capture_pkg::word_t word_data_o
);

	// receiver state
	adc_capture_pkg::rx_state_t state_q;
	// bit position within the frame
	logic [adc_capture_pkg::BIT_CNT_BITS-1:0] bit_cnt_q;
	// active low select, registered
	logic ss_q;
	// incoming frame
	adc_capture_pkg::sample_t shift_q;
	// older sample of the pair
	adc_capture_pkg::sample_t low_half_q;
	// high once the low half is held
	logic pair_tgl_q;
	// state decodes
	logic last_bit;
	logic in_done;

	assign last_bit = (state_q == adc_capture_pkg::SHIFT) &&
		(bit_cnt_q == adc_capture_pkg::LAST_BIT);
	assign in_done = (state_q == adc_capture_pkg::DONE);

	// --------------------------------------------------
	// serial pins
	// --------------------------------------------------
	assign spi_ss_o = ss_q;
	// sck parked high while deselected
	assign spi_sck_o = Baud_Rate | ss_q;

	// last shift cycle
	assign frame_done_o = last_bit;

	// --------------------------------------------------
	// bit counter
	// --------------------------------------------------
	always_ff @(posedge Baud_Rate or posedge rst_i)
	begin
		if (rst_i)
		begin
			bit_cnt_q <= '0;
		end
		else if (state_q == adc_capture_pkg::SHIFT)
		begin
			bit_cnt_q <= bit_cnt_q + 1'b1;
		end
		else
		begin
			bit_cnt_q <= '0;
		end
	end

	// --------------------------------------------------
	// frame FSM
	// --------------------------------------------------
	// IDLE -> SHIFT on start, 16 cycles selected, one DONE cycle
	always_ff @(posedge Baud_Rate or posedge rst_i)
	begin
		if (rst_i)
		begin
			state_q <= adc_capture_pkg::IDLE;
			ss_q <= 1'b1;
		end
		else
		begin
			case (state_q)
				adc_capture_pkg::IDLE:
				begin
					if (conv_start_i)
					begin
						state_q <= adc_capture_pkg::SHIFT;
						ss_q <= 1'b0;
					end
				end
				adc_capture_pkg::SHIFT:
				begin
					// deselect on the edge into DONE
					if (last_bit)
					begin
						state_q <= adc_capture_pkg::DONE;
						ss_q <= 1'b1;
					end
				end
				adc_capture_pkg::DONE:
				begin
					state_q <= adc_capture_pkg::IDLE;
				end
				default:
				begin
					state_q <= adc_capture_pkg::IDLE;
					ss_q <= 1'b1;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// shift register
	// --------------------------------------------------
	// slave changes data after the rising edge
	// sample mid-bit on the falling edge, MSB first
	always_ff @(negedge Baud_Rate)
	begin
		if (!ss_q)
		begin
			shift_q <= {shift_q[adc_capture_pkg::FRAME_BITS-2:0], spi_miso_i};
		end
	end

	// --------------------------------------------------
	// pairing
	// --------------------------------------------------
	// toggle flips once per finished frame
	// cleared whenever pairing is off, dropping a lone half
	always_ff @(posedge Baud_Rate or posedge rst_i)
	begin
		if (rst_i)
		begin
			pair_tgl_q <= 1'b0;
		end
		else if (!pair_en_i)
		begin
			pair_tgl_q <= 1'b0;
		end
		else if (in_done)
		begin
			pair_tgl_q <= ~pair_tgl_q;
		end
	end

	// first frame of a pair parks here
	always_ff @(posedge Baud_Rate)
	begin
		if (in_done && pair_en_i && !pair_tgl_q)
		begin
			low_half_q <= shift_q;
		end
	end

	// second frame pushes, newer sample on top
	assign word_push_o = in_done && pair_en_i && pair_tgl_q;
	assign word_data_o = {shift_q, low_half_q};

endmodule

// ==== source/sample_pacer.sv ====
// conversion pacer
// one start pulse per sample period, skipped near a full buffer
module sample_pacer
(
	input  logic Baud_Rate,
	input  logic rst_i,
	input  logic enable_i,
	input  logic fifo_afull_i,
	output logic conv_start_o
);

	// period counter
	logic [adc_capture_pkg::PACE_CNT_BITS-1:0] pace_cnt_q;
	// end of the current period
	logic period_end;

	assign period_end = (pace_cnt_q == adc_capture_pkg::PACE_LAST);

	// --------------------------------------------------
	// period counter
	// --------------------------------------------------
	// held at zero while capture is off
	// so the first pulse lands a full period after enable
	always_ff @(posedge Baud_Rate or posedge rst_i)
	begin
		if (rst_i)
		begin
			pace_cnt_q <= '0;
		end
		else if (!enable_i)
		begin
			pace_cnt_q <= '0;
		end
		else if (period_end)
		begin
			pace_cnt_q <= '0;
		end
		else
		begin
			pace_cnt_q <= pace_cnt_q + 1'b1;
		end
	end

	// --------------------------------------------------
	// start pulse
	// --------------------------------------------------
	// registered, one cycle wide
	// almost-full drops the pulse, the period still wraps
	always_ff @(posedge Baud_Rate or posedge rst_i)
	begin
		if (rst_i)
		begin
			conv_start_o <= 1'b0;
		end
		else
		begin
			conv_start_o <= enable_i && period_end && !fifo_afull_i;
		end
	end

endmodule

// ==== source/adc_capture_pkg.sv ====
// shared constants, payload types and receiver state encoding
// for the serial sample capture path
package adc_capture_pkg;

	// --------------------------------------------------
	// serial frame and paired word
	// --------------------------------------------------
	// bits per conversion frame
	localparam int FRAME_BITS = 16;
	// two frames per buffered word
	localparam int WORD_BITS = 2 * FRAME_BITS;
	// bit counter runs 0..15 while shifting
	localparam int BIT_CNT_BITS = $clog2(FRAME_BITS);
	localparam logic [BIT_CNT_BITS-1:0] LAST_BIT = BIT_CNT_BITS'(FRAME_BITS - 1);

	// --------------------------------------------------
	// word buffer
	// --------------------------------------------------
	localparam int FIFO_DEPTH = 8;
	// count must hold 0..FIFO_DEPTH
	localparam int FIFO_CNT_BITS = 4;
	localparam int FIFO_PTR_BITS = FIFO_CNT_BITS - 1;
	// no new frame may start at or above this level
	localparam logic [FIFO_CNT_BITS-1:0] AFULL_LEVEL = FIFO_CNT_BITS'(FIFO_DEPTH - 1);

	// --------------------------------------------------
	// conversion pacing
	// --------------------------------------------------
	// at least 18 so a frame and its done cycle finish first
	localparam int SAMPLE_PERIOD = 24;
	localparam int PACE_CNT_BITS = $clog2(SAMPLE_PERIOD);
	localparam logic [PACE_CNT_BITS-1:0] PACE_LAST = PACE_CNT_BITS'(SAMPLE_PERIOD - 1);

	// one frame, one paired word
	typedef logic [FRAME_BITS-1:0] sample_t;
	typedef logic [WORD_BITS-1:0] word_t;

	// receiver state
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		SHIFT = 2'd1,
		DONE  = 2'd2
	} rx_state_t;

endpackage
